// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_JAL    = 7'b1101111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_e;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

endpackage

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

   localparam int CNT_W = 5;
   localparam logic [31:0] RESET_PC = 32'h0000_0000;

   typedef enum logic [1:0] {
      PH_FETCH = 2'd0,
      PH_EXEC  = 2'd1,
      PH_MEM   = 2'd2,
      PH_PCUPD = 2'd3
   } phase_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_XOR = 2'd1,
      ALU_OR  = 2'd2,
      ALU_AND = 2'd3
   } alu_op_e;

   // Where the serial rd bit comes from
   typedef enum logic [1:0] {
      RD_ALU  = 2'd0,
      RD_IMM  = 2'd1,
      RD_LINK = 2'd2,
      RD_LOAD = 2'd3
   } rd_src_e;

endpackage

`default_nettype wire

// File: decode_if.sv
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
   import rv_isa_pkg::*;
   import core_pkg::*;

   opcode_e           opcode;
   alu_op_e           alu_op;
   logic              sub;
   logic              use_imm;
   rd_src_e           rd_src;
   logic              rd_wen;
   logic [REG_AW-1:0] rd_addr;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic              br_ne;
   // Immediate bit selected by the current count
   logic              imm_bit;

   modport dec (
      output opcode, alu_op, sub, use_imm, rd_src, rd_wen,
      output rd_addr, rs1_addr, rs2_addr, br_ne, imm_bit
   );

   modport exe (
      input opcode, alu_op, sub, use_imm, rd_src, rd_wen,
      input rd_addr, rs1_addr, rs2_addr, br_ne, imm_bit
   );

endinterface

`default_nettype wire

// File: serial_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module serial_sequencer (
   input  wire                         clk,
   input  wire                         i_rst_n,
   input  wire                         i_ibus_ack,
   input  wire                         i_dbus_ack,
   decode_if.exe                       i_dec,
   input  wire                         i_eq,
   output core_pkg::phase_e            o_phase,
   output logic [core_pkg::CNT_W-1:0]  o_cnt,
   output logic                        o_cnt_en,
   output logic                        o_link_bit,
   output logic [rv_isa_pkg::XLEN-1:0] o_ibus_adr,
   output logic                        o_ibus_cyc,
   output logic                        o_dbus_cyc,
   output logic                        o_dbus_we
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   phase_e           phase;
   logic [CNT_W-1:0] cnt;
   logic [XLEN-1:0]  pc;
   logic             carry;
   logic             cnt_last;
   logic             mem_op;
   logic             take;
   logic             a_bit;
   logic             b_bit;
   logic             cin;
   logic             sum;

   assign cnt_last = (cnt == '1);
   assign mem_op   = (i_dec.opcode == OP_LOAD) || (i_dec.opcode == OP_STORE);
   assign take     = (i_dec.opcode == OP_JAL) ||
                     ((i_dec.opcode == OP_BRANCH) && (i_eq != i_dec.br_ne));

   // One serial adder for PC+4 in EXEC and the next PC in PCUPD
   assign a_bit = (phase == PH_PCUPD) ? pc[0] : pc[cnt];
   assign b_bit = ((phase == PH_PCUPD) && take) ? i_dec.imm_bit : (cnt == CNT_W'(2));
   assign cin   = (cnt == '0) ? 1'b0 : carry;
   assign sum   = a_bit ^ b_bit ^ cin;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         phase <= PH_FETCH;
         cnt   <= '0;
         carry <= 1'b0;
         pc    <= RESET_PC;
      end else begin
         if (o_cnt_en) begin
            cnt   <= cnt + CNT_W'(1);
            carry <= (a_bit & b_bit) | (a_bit & cin) | (b_bit & cin);
         end
         // PC rotates right with the new bit entering at the top
         if (phase == PH_PCUPD) begin
            pc <= {sum, pc[XLEN-1:1]};
         end
         case (phase)
            PH_FETCH: if (i_ibus_ack) phase <= PH_EXEC;
            PH_EXEC:  if (cnt_last) phase <= mem_op ? PH_MEM : PH_PCUPD;
            PH_MEM:   if (i_dbus_ack) phase <= PH_PCUPD;
            PH_PCUPD: if (cnt_last) phase <= PH_FETCH;
            default:  phase <= PH_FETCH;
         endcase
      end
   end

   assign o_phase    = phase;
   assign o_cnt      = cnt;
   assign o_cnt_en   = (phase == PH_EXEC) || (phase == PH_PCUPD);
   assign o_link_bit = sum;
   assign o_ibus_adr = pc;
   assign o_ibus_cyc = (phase == PH_FETCH);
   assign o_dbus_cyc = (phase == PH_MEM);
   assign o_dbus_we  = (i_dec.opcode == OP_STORE);

endmodule

`default_nettype wire

// File: serial_decode.sv
`timescale 1ns/1ns
`default_nettype none

module serial_decode (
   input  wire                         clk,
   input  wire                         i_rst_n,
   input  wire [rv_isa_pkg::XLEN-1:0]  i_ibus_rdt,
   input  wire                         i_ibus_ack,
   input  wire                         i_ibus_cyc,
   input  wire [core_pkg::CNT_W-1:0]   i_cnt,
   decode_if.dec                       o_dec
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [XLEN-1:0] instr;
   logic [XLEN-1:0] imm;
   opcode_e         opcode;
   logic [2:0]      funct3;
   logic            f3_ok;
   logic            f7_ok;
   logic            wr_ok;
   alu_op_e         f3_op;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         instr <= '0;
      end else if (i_ibus_cyc && i_ibus_ack) begin
         instr <= i_ibus_rdt;
      end
   end

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign f3_ok  = funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
   // Only SUB may set bit 30
   assign f7_ok  = (instr[31:25] == 7'h00) || ((instr[31:25] == 7'h20) && (funct3 == F3_ADD));

   always_comb begin
      case (funct3)
         F3_XOR:  f3_op = ALU_XOR;
         F3_OR:   f3_op = ALU_OR;
         F3_AND:  f3_op = ALU_AND;
         default: f3_op = ALU_ADD;
      endcase
   end

   always_comb begin
      o_dec.alu_op  = ALU_ADD;
      o_dec.use_imm = 1'b1;
      o_dec.rd_src  = RD_ALU;
      wr_ok         = 1'b0;
      imm           = {{21{instr[31]}}, instr[30:20]};
      case (opcode)
         OP_LUI: begin
            o_dec.rd_src = RD_IMM;
            imm          = {instr[31:12], 12'b0};
            wr_ok        = 1'b1;
         end
         OP_JAL: begin
            o_dec.rd_src = RD_LINK;
            imm          = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            wr_ok        = 1'b1;
         end
         OP_BRANCH: begin
            o_dec.use_imm = 1'b0;
            imm           = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         end
         OP_LOAD: begin
            o_dec.rd_src = RD_LOAD;
            wr_ok        = 1'b1;
         end
         OP_STORE: begin
            imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
         end
         OP_IMM: begin
            o_dec.alu_op = f3_op;
            wr_ok        = f3_ok;
         end
         OP_REG: begin
            o_dec.alu_op  = f3_op;
            o_dec.use_imm = 1'b0;
            wr_ok         = f3_ok && f7_ok;
         end
         default: ;
      endcase
   end

   assign o_dec.opcode   = opcode;
   assign o_dec.sub      = (opcode == OP_REG) && (funct3 == F3_ADD) && instr[30];
   assign o_dec.rd_addr  = instr[11:7];
   assign o_dec.rs1_addr = instr[19:15];
   assign o_dec.rs2_addr = instr[24:20];
   assign o_dec.rd_wen   = wr_ok && (instr[11:7] != '0);
   assign o_dec.br_ne    = (funct3 == F3_BNE);
   assign o_dec.imm_bit  = imm[i_cnt];

endmodule

`default_nettype wire

// File: serial_alu.sv
`timescale 1ns/1ns
`default_nettype none

module serial_alu (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire core_pkg::phase_e      i_phase,
   input  wire [core_pkg::CNT_W-1:0]  i_cnt,
   input  wire                        i_cnt_en,
   input  wire                        i_rs1,
   input  wire                        i_rs2,
   decode_if.exe                      i_dec,
   output logic                       o_res,
   output logic                       o_eq
);
   import core_pkg::*;

   logic exec_en;
   logic first;
   logic op_b;
   logic b_eff;
   logic cin;
   logic sum;
   logic carry;
   logic eq;

   assign exec_en = i_cnt_en && (i_phase == PH_EXEC);
   assign first   = (i_cnt == '0);
   assign op_b    = i_dec.use_imm ? i_dec.imm_bit : i_rs2;

   // Subtract as rs1 + ~b + 1
   assign b_eff = op_b ^ i_dec.sub;
   assign cin   = first ? i_dec.sub : carry;
   assign sum   = i_rs1 ^ b_eff ^ cin;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
         eq    <= 1'b0;
      end else if (exec_en) begin
         carry <= (i_rs1 & b_eff) | (i_rs1 & cin) | (b_eff & cin);
         eq    <= (first | eq) & (i_rs1 ~^ i_rs2);
      end
   end

   always_comb begin
      case (i_dec.alu_op)
         ALU_XOR: o_res = i_rs1 ^ op_b;
         ALU_OR:  o_res = i_rs1 | op_b;
         ALU_AND: o_res = i_rs1 & op_b;
         default: o_res = sum;
      endcase
   end

   // Held after EXEC for the branch decision
   assign o_eq = eq;

endmodule

`default_nettype wire

// File: serial_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module serial_regfile (
   input  wire                        clk,
   input  wire core_pkg::phase_e      i_phase,
   input  wire [core_pkg::CNT_W-1:0]  i_cnt,
   input  wire                        i_cnt_en,
   decode_if.exe                      i_dec,
   input  wire                        i_alu_bit,
   input  wire                        i_link_bit,
   input  wire                        i_load_bit,
   output logic                       o_rs1,
   output logic                       o_rs2
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [XLEN-1:0] regs [2**REG_AW];
   phase_e          wr_phase;
   logic            wen;
   logic            wbit;

   // Load data only arrives after MEM
   assign wr_phase = (i_dec.rd_src == RD_LOAD) ? PH_PCUPD : PH_EXEC;
   assign wen      = i_dec.rd_wen && i_cnt_en && (i_phase == wr_phase);

   always_comb begin
      case (i_dec.rd_src)
         RD_IMM:  wbit = i_dec.imm_bit;
         RD_LINK: wbit = i_link_bit;
         RD_LOAD: wbit = i_load_bit;
         default: wbit = i_alu_bit;
      endcase
   end

   always_ff @(posedge clk) begin
      if (wen) begin
         regs[i_dec.rd_addr][i_cnt] <= wbit;
      end
   end

   // x0 reads as zero
   assign o_rs1 = (i_dec.rs1_addr == '0) ? 1'b0 : regs[i_dec.rs1_addr][i_cnt];
   assign o_rs2 = (i_dec.rs2_addr == '0) ? 1'b0 : regs[i_dec.rs2_addr][i_cnt];

endmodule

`default_nettype wire

// File: serial_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module serial_lsu (
   input  wire                         clk,
   input  wire core_pkg::phase_e       i_phase,
   input  wire                         i_cnt_en,
   input  wire                         i_alu_bit,
   input  wire                         i_rs2,
   input  wire [rv_isa_pkg::XLEN-1:0]  i_dbus_rdt,
   input  wire                         i_dbus_ack,
   input  wire                         i_dbus_cyc,
   output logic                        o_load_bit,
   output logic [rv_isa_pkg::XLEN-1:0] o_dbus_adr,
   output logic [rv_isa_pkg::XLEN-1:0] o_dbus_dat
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [XLEN-1:0] adr;
   logic [XLEN-1:0] dat;
   logic [XLEN-1:0] ldbuf;
   logic            exec_en;
   logic            pcupd_en;

   assign exec_en  = i_cnt_en && (i_phase == PH_EXEC);
   assign pcupd_en = i_cnt_en && (i_phase == PH_PCUPD);

   // Shifted in LSB first so bit 0 ends up at the bottom
   always_ff @(posedge clk) begin
      if (exec_en) begin
         adr <= {i_alu_bit, adr[XLEN-1:1]};
         dat <= {i_rs2, dat[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_dbus_cyc && i_dbus_ack) begin
         ldbuf <= i_dbus_rdt;
      end else if (pcupd_en) begin
         ldbuf <= {1'b0, ldbuf[XLEN-1:1]};
      end
   end

   assign o_load_bit = ldbuf[0];
   assign o_dbus_adr = {adr[XLEN-1:2], 2'b00};
   assign o_dbus_dat = dat;

endmodule

`default_nettype wire

// File: serial_rv_top.sv
`timescale 1ns/1ns
`default_nettype none

module serial_rv_top (
   input  wire                         clk,
   input  wire                         i_rst_n,
   input  wire [rv_isa_pkg::XLEN-1:0]  i_ibus_rdt,
   input  wire                         i_ibus_ack,
   input  wire [rv_isa_pkg::XLEN-1:0]  i_dbus_rdt,
   input  wire                         i_dbus_ack,
   output logic [rv_isa_pkg::XLEN-1:0] o_ibus_adr,
   output logic                        o_ibus_cyc,
   output logic [rv_isa_pkg::XLEN-1:0] o_dbus_adr,
   output logic [rv_isa_pkg::XLEN-1:0] o_dbus_dat,
   output logic                        o_dbus_we,
   output logic                        o_dbus_cyc
);
   import core_pkg::*;

   phase_e           phase;
   logic [CNT_W-1:0] cnt;
   logic             cnt_en;
   logic             link_bit;
   logic             eq;
   logic             rs1;
   logic             rs2;
   logic             alu_res;
   logic             load_bit;

   decode_if dec_if ();

   serial_sequencer sequencer (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_dec      (dec_if),
      .i_eq       (eq),
      .o_phase    (phase),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_link_bit (link_bit),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_dbus_we  (o_dbus_we)
   );

   serial_decode decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_cyc (o_ibus_cyc),
      .i_cnt      (cnt),
      .o_dec      (dec_if)
   );

   serial_alu alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_phase  (phase),
      .i_cnt    (cnt),
      .i_cnt_en (cnt_en),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_dec    (dec_if),
      .o_res    (alu_res),
      .o_eq     (eq)
   );

   serial_regfile regfile (
      .clk        (clk),
      .i_phase    (phase),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_dec      (dec_if),
      .i_alu_bit  (alu_res),
      .i_link_bit (link_bit),
      .i_load_bit (load_bit),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serial_lsu lsu (
      .clk        (clk),
      .i_phase    (phase),
      .i_cnt_en   (cnt_en),
      .i_alu_bit  (alu_res),
      .i_rs2      (rs2),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_cyc (o_dbus_cyc),
      .o_load_bit (load_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

`default_nettype wire

// File: serial_rv_sva.sv
`timescale 1ns/1ns
`default_nettype none

module serial_rv_sva (
   input wire        clk,
   input wire        i_rst_n,
   input wire        i_ibus_cyc,
   input wire        i_ibus_ack,
   input wire [31:0] i_ibus_adr,
   input wire        i_dbus_cyc,
   input wire        i_dbus_ack,
   input wire [31:0] i_dbus_adr,
   input wire [31:0] i_dbus_dat,
   input wire        i_dbus_we
);

   no_overlap: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus cycles overlap");

   // Request held until ack
   ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_ibus_cyc && !i_ibus_ack) |=> (i_ibus_cyc && $stable(i_ibus_adr)))
      else $error("instruction bus request changed before ack");

   dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_dbus_cyc && !i_dbus_ack) |=> (i_dbus_cyc && $stable(i_dbus_adr) &&
                                       $stable(i_dbus_dat) && $stable(i_dbus_we)))
      else $error("data bus request changed before ack");

   dbus_align: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc |-> (i_dbus_adr[1:0] == 2'b00))
      else $error("data bus address not word aligned");

endmodule

bind serial_rv_top serial_rv_sva i_sva (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .i_ibus_adr (o_ibus_adr),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_ack (i_dbus_ack),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat),
   .i_dbus_we  (o_dbus_we)
);

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
   parameter int N_INSTR = 400
) (
   input  wire        clk,
   input  wire        i_rst_n,
   input  wire [31:0] i_ibus_adr,
   input  wire        i_ibus_cyc,
   input  wire [31:0] i_ibus_rdt,
   input  wire        i_ibus_ack,
   input  wire [31:0] i_dbus_adr,
   input  wire [31:0] i_dbus_dat,
   input  wire        i_dbus_we,
   input  wire        i_dbus_cyc,
   input  wire [31:0] i_dbus_rdt,
   input  wire        i_dbus_ack,
   output logic       o_done,
   output int         o_checks,
   output int         o_errors
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [31:0] regs [32];
   int          src_beh [32];
   int          nchk [1:6];
   int          nerr [1:6];
   logic [31:0] pc;
   logic [31:0] pend;
   logic        pend_valid;
   logic        mem_seen;
   logic        any_mem;
   logic [31:0] ld_data;
   int          n_instr;
   logic        i_hold;
   logic        d_hold;
   logic [31:0] i_adr_q;
   logic [31:0] d_adr_q;
   logic [31:0] d_dat_q;
   logic        d_we_q;
   string       beh_name [1:6] = '{"reset state", "ALU results", "control flow",
                                   "load/store", "link and x0", "ack delays"};

   function automatic logic is_mem(input logic [31:0] ins);
      return (ins[6:0] == OP_LOAD) || (ins[6:0] == OP_STORE);
   endfunction

   function automatic logic [31:0] mem_addr(input logic [31:0] ins);
      logic [31:0] imm;
      imm = (ins[6:0] == OP_STORE) ? {{20{ins[31]}}, ins[31:25], ins[11:7]}
                                   : {{20{ins[31]}}, ins[31:20]};
      return (regs[ins[19:15]] + imm) & ~32'h3;
   endfunction

   task automatic check(input int beh, input string name, input logic [31:0] exp,
                        input logic [31:0] act);
      nchk[beh]++;
      if (exp !== act) begin
         nerr[beh]++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic flag(input int beh, input string what);
      nchk[beh]++;
      nerr[beh]++;
      $display("Error: %s", what);
   endtask

   // Architectural step of one instruction
   task automatic step_model(input logic [31:0] ins);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] res;
      logic [31:0] npc;
      logic [2:0]  f3;
      logic [4:0]  rd;
      logic        wr;
      int          beh;
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      f3    = ins[14:12];
      rd    = ins[11:7];
      npc   = pc + 32'd4;
      res   = '0;
      wr    = 1'b0;
      beh   = 2;
      case (ins[6:0])
         OP_LUI: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         OP_JAL: begin
            res = pc + 32'd4;
            wr  = 1'b1;
            beh = 5;
            npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         OP_BRANCH: begin
            if ((a == b) != (f3 == F3_BNE))
               npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         OP_LOAD: begin
            res = ld_data;
            wr  = 1'b1;
            beh = 4;
         end
         OP_IMM, OP_REG: begin
            if (ins[6:0] == OP_IMM)
               b = imm_i;
            case (f3)
               F3_XOR:  res = a ^ b;
               F3_OR:   res = a | b;
               F3_AND:  res = a & b;
               default: res = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
            endcase
            wr = 1'b1;
         end
         default: ;
      endcase
      if (wr && rd != 0) begin
         regs[rd]    = res;
         src_beh[rd] = beh;
      end
      pc = npc;
   endtask

   always @(posedge clk) begin
      if (!i_rst_n) begin
         for (int r = 0; r < 32; r++) begin
            regs[r]    = '0;
            src_beh[r] = (r == 0) ? 5 : 2;
         end
         for (int b = 1; b <= 6; b++) begin
            nchk[b] = 0;
            nerr[b] = 0;
         end
         pc         = RESET_PC;
         pend_valid = 1'b0;
         mem_seen   = 1'b0;
         any_mem    = 1'b0;
         n_instr    = 0;
         i_hold     = 1'b0;
         d_hold     = 1'b0;
         o_done     = 1'b0;
         o_checks   = 0;
         o_errors   = 0;
      end else if (!o_done) begin
         // Request must not move while waiting for ack
         if (i_ibus_cyc) begin
            if (i_hold)
               check(6, "o_ibus_adr", i_adr_q, i_ibus_adr);
            i_adr_q = i_ibus_adr;
            i_hold  = !i_ibus_ack;
         end
         if (i_dbus_cyc) begin
            if (d_hold) begin
               check(6, "o_dbus_adr", d_adr_q, i_dbus_adr);
               check(6, "o_dbus_dat", d_dat_q, i_dbus_dat);
               check(6, "o_dbus_we", 32'(d_we_q), 32'(i_dbus_we));
            end
            d_adr_q = i_dbus_adr;
            d_dat_q = i_dbus_dat;
            d_we_q  = i_dbus_we;
            d_hold  = !i_dbus_ack;
         end
         if (!any_mem && i_dbus_cyc && !(pend_valid && is_mem(pend)))
            flag(1, "data bus cycle started before the first load or store");
         if (i_ibus_cyc && i_ibus_ack) begin
            if (pend_valid) begin
               if (is_mem(pend) && !mem_seen)
                  flag(4, "load or store finished without a data bus cycle");
               step_model(pend);
               n_instr++;
            end
            check(pend_valid ? 3 : 1, "o_ibus_adr", pc, i_ibus_adr);
            pend       = i_ibus_rdt;
            pend_valid = 1'b1;
            mem_seen   = 1'b0;
         end
         if (i_dbus_cyc && i_dbus_ack) begin
            if (!(pend_valid && is_mem(pend))) begin
               flag(4, "data bus cycle for an instruction that is no load or store");
            end else begin
               check(4, "o_dbus_adr", mem_addr(pend), i_dbus_adr);
               check(4, "o_dbus_we", 32'(pend[6:0] == OP_STORE), 32'(i_dbus_we));
               if (pend[6:0] == OP_STORE)
                  check(src_beh[pend[24:20]], "o_dbus_dat", regs[pend[24:20]], i_dbus_dat);
               else
                  ld_data = i_dbus_rdt;
               mem_seen = 1'b1;
               any_mem  = 1'b1;
            end
         end
         if (n_instr >= N_INSTR) begin
            for (int b = 1; b <= 6; b++) begin
               $display("Behavior %0d (%s): %0d checks, %0d errors, %s", b, beh_name[b],
                        nchk[b], nerr[b], (nerr[b] == 0) ? "ok" : "FAILED");
               o_checks += nchk[b];
               o_errors += nerr[b];
            end
            o_done = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_serial_rv.sv
`timescale 1ns/1ns
`default_nettype none

module tb_serial_rv;
   import rv_isa_pkg::*;

   localparam int N_INSTR    = 400;
   localparam int CLK_NS     = 8;
   // Worst case ack delay of 3 waits stretches a bus access to 4 cycles
   localparam longint TIMEOUT_NS = longint'(N_INSTR) * 80 * 4 * CLK_NS;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] i_dbus_rdt;
   logic        i_dbus_ack;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_we;
   logic        o_dbus_cyc;
   logic        done;
   int          n_checks;
   int          n_errors;

   logic [31:0] imem [256];
   logic [31:0] dmem [64];
   logic [31:0] lfsr_state;
   logic [1:0]  iwait;
   logic [1:0]  dwait;

   serial_rv_top i_serial_rv_top (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc)
   );

   tb_checker #(.N_INSTR(N_INSTR)) u_checker (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_adr (o_ibus_adr),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_adr (o_dbus_adr),
      .i_dbus_dat (o_dbus_dat),
      .i_dbus_we  (o_dbus_we),
      .i_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_done     (done),
      .o_checks   (n_checks),
      .o_errors   (n_errors)
   );

   always #(CLK_NS / 2) clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v          = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic build_program();
      logic [31:0] sel;
      logic [31:0] rd;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] imm;
      logic [31:0] ow;
      logic [31:0] off;
      for (int a = 0; a < 256; a++) begin
         draw_bits(4, sel);
         draw_bits(3, rd);
         draw_bits(3, r1);
         draw_bits(3, r2);
         draw_bits(12, imm);
         draw_bits(4, ow);
         // Nonzero word offset in -8..7 words
         off = (ow[3:0] == 0) ? 32'd4 : {{28{ow[3]}}, ow[3:0]} << 2;
         if (a < 7) begin
            sel = 6;
            rd  = a + 1;
            r1  = 0;
         end
         case (sel)
            0: imem[a] = {imm[11:0], r2[4:0], r1[2:0], rd[4:0], OP_LUI};
            1: imem[a] = {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
            2, 3: imem[a] = {off[12], off[10:5], r2[4:0], r1[4:0],
                             (sel == 2) ? F3_BEQ : F3_BNE, off[4:1], off[11], OP_BRANCH};
            4: imem[a] = {imm[11:0], r1[4:0], 3'b010, rd[4:0], OP_LOAD};
            5, 15: imem[a] = {imm[11:5], r2[4:0], r1[4:0], 3'b010, imm[4:0], OP_STORE};
            6: imem[a] = {imm[11:0], r1[4:0], F3_ADD, rd[4:0], OP_IMM};
            7: imem[a] = {imm[11:0], r1[4:0], F3_XOR, rd[4:0], OP_IMM};
            8: imem[a] = {imm[11:0], r1[4:0], F3_OR, rd[4:0], OP_IMM};
            9: imem[a] = {imm[11:0], r1[4:0], F3_AND, rd[4:0], OP_IMM};
            10: imem[a] = {7'h00, r2[4:0], r1[4:0], F3_ADD, rd[4:0], OP_REG};
            11: imem[a] = {7'h20, r2[4:0], r1[4:0], F3_ADD, rd[4:0], OP_REG};
            12: imem[a] = {7'h00, r2[4:0], r1[4:0], F3_XOR, rd[4:0], OP_REG};
            13: imem[a] = {7'h00, r2[4:0], r1[4:0], F3_OR, rd[4:0], OP_REG};
            default: imem[a] = {7'h00, r2[4:0], r1[4:0], F3_AND, rd[4:0], OP_REG};
         endcase
      end
      for (int a = 0; a < 64; a++)
         dmem[a] = (a * 32'h9e37_79b9) ^ 32'h1234_5678;
   endtask

   // Bus responder acking after 0 to 3 wait cycles
   always @(posedge clk) begin
      logic [31:0] r;
      if (!i_rst_n) begin
         i_ibus_ack <= 1'b0;
         i_dbus_ack <= 1'b0;
      end else begin
         if (i_ibus_ack) begin
            i_ibus_ack <= 1'b0;
            draw_bits(2, r);
            iwait <= r[1:0];
         end else if (o_ibus_cyc) begin
            if (iwait == 0) begin
               i_ibus_ack <= 1'b1;
               i_ibus_rdt <= imem[o_ibus_adr[9:2]];
            end else begin
               iwait <= iwait - 2'd1;
            end
         end
         if (i_dbus_ack) begin
            i_dbus_ack <= 1'b0;
            draw_bits(2, r);
            dwait <= r[1:0];
         end else if (o_dbus_cyc) begin
            if (dwait == 0) begin
               i_dbus_ack <= 1'b1;
               i_dbus_rdt <= dmem[o_dbus_adr[7:2]];
               if (o_dbus_we)
                  dmem[o_dbus_adr[7:2]] <= o_dbus_dat;
            end else begin
               dwait <= dwait - 2'd1;
            end
         end
      end
   end

   initial begin
      logic [31:0] r;
      clk        = 1'b0;
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      lfsr_state = 32'ha103_715b;
      build_program();
      draw_bits(2, r);
      iwait = r[1:0];
      draw_bits(2, r);
      dwait = r[1:0];
      repeat (3) @(posedge clk);
      i_rst_n <= 1'b1;
      wait (done);
      @(posedge clk);
      $display("Summary: %0d checks, %0d errors over %0d instructions",
               n_checks, n_errors, N_INSTR);
      if (n_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the processor did not retire %0d instructions in time", N_INSTR);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: serial_rv.f
rv_isa_pkg.sv
core_pkg.sv
decode_if.sv
serial_sequencer.sv
serial_decode.sv
serial_alu.sv
serial_regfile.sv
serial_lsu.sv
serial_rv_top.sv
serial_rv_sva.sv
tb_checker.sv
tb_serial_rv.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the serial_rv simulation, status follows the testbench result
verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_rv \
   -f serial_rv.f -o sim_serial_rv &&
./obj_dir/sim_serial_rv | tee /dev/stderr | grep -q "^Finished with no errors$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
